// File: src/ntt_defines_pkg.sv
// Shared constants and types for the pointwise polynomial engine, referenced by scoped name

package ntt_defines_pkg;

    // ============================================================
    // ML-DSA ring parameters
    // ============================================================

    // Coefficient width and polynomial size
    localparam int COEFF_W = 23;
    localparam int MLDSA_N = 256;
    localparam int ADDR_W  = 8;

    // Modulus Q = 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] MLDSA_Q = 23'd8380417;

    // Cycles from a read address issue to the matching write into C
    localparam int PWO_LATENCY = 3;

    // ============================================================
    // Types
    // ============================================================

    // Coefficient in the range 0 to Q-1
    typedef logic [COEFF_W-1:0] coeff_t;

    // Word address inside one coefficient memory
    typedef logic [ADDR_W-1:0] coeff_addr_t;

    // Pointwise operation modes
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } mode_t;

    // Read controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } pwo_state_t;

endpackage

// File: src/ntt_coeff_ram.sv
// Coefficient register file with one write port and one registered read port, used for A, B and C
`timescale 1ns/100ps

module ntt_coeff_ram (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        zeroize,

    input  logic                        wr_en,
    input  ntt_defines_pkg::coeff_addr_t wr_addr,
    input  ntt_defines_pkg::coeff_t     wr_data,

    input  logic                        rd_en,
    input  ntt_defines_pkg::coeff_addr_t rd_addr,
    output ntt_defines_pkg::coeff_t     rd_data
);

    // One polynomial of coefficients
    ntt_defines_pkg::coeff_t mem [ntt_defines_pkg::MLDSA_N];

    // Storage array, cleared on reset or zeroize
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            for (int i = 0; i < ntt_defines_pkg::MLDSA_N; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle of latency
    // A read of a word written on the same edge returns the old value
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: src/pwo_read_ctrl.sv
// Run controller that takes the start strobe, sweeps the A and B read addresses and drives busy
`timescale 1ns/100ps

module pwo_read_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         pwo_enable,
    input  ntt_defines_pkg::mode_t       mode,

    output logic                         rd_en,
    output ntt_defines_pkg::coeff_addr_t rd_addr,

    output logic                         issue_valid,
    output ntt_defines_pkg::coeff_addr_t issue_addr,

    output ntt_defines_pkg::mode_t       run_mode,
    output logic                         busy
);

    ntt_defines_pkg::pwo_state_t   state;
    ntt_defines_pkg::pwo_state_t   next_state;

    // Read address in RUN, drain cycle count in DRAIN
    ntt_defines_pkg::coeff_addr_t  cnt;

    logic last_addr;
    logic drain_end;

    assign last_addr = (cnt == ntt_defines_pkg::coeff_addr_t'(ntt_defines_pkg::MLDSA_N - 1));
    assign drain_end = (cnt == ntt_defines_pkg::coeff_addr_t'(ntt_defines_pkg::PWO_LATENCY));

    // ============================================================
    // FSM
    // ============================================================

    always_comb begin
        next_state = state;
        unique case (state)
            ntt_defines_pkg::IDLE: begin
                if (pwo_enable) begin
                    next_state = ntt_defines_pkg::RUN;
                end
            end
            ntt_defines_pkg::RUN: begin
                if (last_addr) begin
                    next_state = ntt_defines_pkg::DRAIN;
                end
            end
            ntt_defines_pkg::DRAIN: begin
                // Hold until the final write has been counted and done pulses
                if (drain_end) begin
                    next_state = ntt_defines_pkg::IDLE;
                end
            end
            default: next_state = ntt_defines_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ntt_defines_pkg::IDLE;
            cnt      <= '0;
            run_mode <= ntt_defines_pkg::pwm;
        end else begin
            state <= next_state;
            if (state == ntt_defines_pkg::IDLE) begin
                cnt <= '0;
                // Mode is only taken with the start strobe
                if (pwo_enable) begin
                    run_mode <= mode;
                end
            end else if (state == ntt_defines_pkg::DRAIN && drain_end) begin
                cnt <= '0;
            end else begin
                // Wraps from 255 to 0 on entry to DRAIN
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign rd_en   = (state == ntt_defines_pkg::RUN);
    assign rd_addr = cnt;
    assign busy    = (state != ntt_defines_pkg::IDLE);

    // Issue tracks the RAM read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        issue_addr <= rd_addr;
    end

endmodule

// File: src/pwo_mod_mul.sv
// Two-stage modular multiplier modulo Q, product register followed by folding reduction
`timescale 1ns/100ps

module pwo_mod_mul (
    input  logic                    clk,
    input  logic                    rst_n,

    input  ntt_defines_pkg::coeff_t a,
    input  ntt_defines_pkg::coeff_t b,
    output ntt_defines_pkg::coeff_t product
);

    // ============================================================
    // Stage 1: full product
    // ============================================================

    logic [2*ntt_defines_pkg::COEFF_W-1:0] prod_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_q <= '0;
        end else begin
            prod_q <= a * b;
        end
    end

    // ============================================================
    // Stage 2: reduction
    // ============================================================

    // 2^23 = 2^13 - 1 (mod Q), so h*2^23 + l folds to h*2^13 - h + l

    // First fold of the 46-bit product, result below 2^36
    logic [22:0] h0;
    logic [22:0] l0;
    logic [36:0] r1;

    // Second fold, result below 2^26 + 2^23
    logic [13:0] h1;
    logic [22:0] l1;
    logic [27:0] r2;

    // Small third fold, result below 2Q
    logic [4:0]  h2;
    logic [22:0] l2;
    logic [23:0] r3;

    logic [23:0] r3_sub;
    ntt_defines_pkg::coeff_t reduced;

    assign h0 = prod_q[45:23];
    assign l0 = prod_q[22:0];
    assign r1 = {1'b0, h0, 13'b0} - {14'b0, h0} + {14'b0, l0};

    assign h1 = r1[36:23];
    assign l1 = r1[22:0];
    assign r2 = {1'b0, h1, 13'b0} - {14'b0, h1} + {5'b0, l1};

    assign h2 = r2[27:23];
    assign l2 = r2[22:0];
    assign r3 = {6'b0, h2, 13'b0} - {19'b0, h2} + {1'b0, l2};

    // One conditional subtraction finishes the residue
    assign r3_sub  = r3 - {1'b0, ntt_defines_pkg::MLDSA_Q};
    assign reduced = (r3 >= {1'b0, ntt_defines_pkg::MLDSA_Q}) ? r3_sub[22:0] : r3[22:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            product <= '0;
        end else begin
            product <= reduced;
        end
    end

endmodule

// File: src/pwo_mod_addsub.sv
// One-stage modular adder and subtractor modulo Q, both results registered every cycle
`timescale 1ns/100ps

module pwo_mod_addsub (
    input  logic                    clk,
    input  logic                    rst_n,

    input  ntt_defines_pkg::coeff_t a,
    input  ntt_defines_pkg::coeff_t b,
    output ntt_defines_pkg::coeff_t sum,
    output ntt_defines_pkg::coeff_t diff
);

    logic [ntt_defines_pkg::COEFF_W:0] q_ext;
    logic [ntt_defines_pkg::COEFF_W:0] raw_sum;
    logic [ntt_defines_pkg::COEFF_W:0] sum_sub;
    logic [ntt_defines_pkg::COEFF_W:0] raw_diff;
    logic [ntt_defines_pkg::COEFF_W:0] diff_add;

    assign q_ext = {1'b0, ntt_defines_pkg::MLDSA_Q};

    // a + b is below 2Q, at most one subtraction
    assign raw_sum = {1'b0, a} + {1'b0, b};
    assign sum_sub = raw_sum - q_ext;

    // Negative difference wraps, adding Q brings it back into range
    assign raw_diff = {1'b0, a} - {1'b0, b};
    assign diff_add = raw_diff + q_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum  <= '0;
            diff <= '0;
        end else begin
            sum  <= (raw_sum >= q_ext) ? sum_sub[ntt_defines_pkg::COEFF_W-1:0]
                                       : raw_sum[ntt_defines_pkg::COEFF_W-1:0];
            diff <= (a < b) ? diff_add[ntt_defines_pkg::COEFF_W-1:0]
                            : raw_diff[ntt_defines_pkg::COEFF_W-1:0];
        end
    end

endmodule

// File: src/pwo_writeback.sv
// Writeback stage that aligns the arithmetic results, selects by mode, writes C and pulses done
`timescale 1ns/100ps

module pwo_writeback (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         issue_valid,
    input  ntt_defines_pkg::coeff_addr_t issue_addr,
    input  ntt_defines_pkg::mode_t       run_mode,

    input  ntt_defines_pkg::coeff_t      product,
    input  ntt_defines_pkg::coeff_t      sum,
    input  ntt_defines_pkg::coeff_t      diff,

    output logic                         wr_en,
    output ntt_defines_pkg::coeff_addr_t wr_addr,
    output ntt_defines_pkg::coeff_t      wr_data,
    output logic                         done
);

    // ============================================================
    // Alignment
    // ============================================================

    // Issue side matches the two-stage multiplier
    logic                         valid_d1;
    logic                         valid_d2;
    ntt_defines_pkg::coeff_addr_t addr_d1;
    ntt_defines_pkg::coeff_addr_t addr_d2;

    // Adder path is one stage short of the multiplier
    ntt_defines_pkg::coeff_t      sum_d1;
    ntt_defines_pkg::coeff_t      diff_d1;

    ntt_defines_pkg::coeff_addr_t wr_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            valid_d1 <= issue_valid;
            valid_d2 <= valid_d1;
        end
    end

    always_ff @(posedge clk) begin
        addr_d1 <= issue_addr;
        addr_d2 <= addr_d1;
        sum_d1  <= sum;
        diff_d1 <= diff;
    end

    // ============================================================
    // Result select and write port of C
    // ============================================================

    always_comb begin
        unique case (run_mode)
            ntt_defines_pkg::pwm: wr_data = product;
            ntt_defines_pkg::pwa: wr_data = sum_d1;
            ntt_defines_pkg::pws: wr_data = diff_d1;
            default:              wr_data = product;
        endcase
    end

    assign wr_en   = valid_d2;
    assign wr_addr = addr_d2;

    // Done follows the last write of the polynomial by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            done   <= 1'b0;
        end else begin
            done <= wr_en &&
                    (wr_cnt == ntt_defines_pkg::coeff_addr_t'(ntt_defines_pkg::MLDSA_N - 1));
            if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

// File: src/pwo_wrapper.sv
// Top level of the pointwise engine, connecting memories A, B and C to the run datapath
`timescale 1ns/100ps

module pwo_wrapper (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         zeroize,

    input  logic                         load_a_en,
    input  logic                         load_b_en,
    input  ntt_defines_pkg::coeff_addr_t load_addr,
    input  ntt_defines_pkg::coeff_t      load_data,

    input  logic                         pwo_enable,
    input  ntt_defines_pkg::mode_t       mode,

    input  logic                         result_rd_en,
    input  ntt_defines_pkg::coeff_addr_t result_addr,
    output ntt_defines_pkg::coeff_t      result_data,

    output logic                         busy,
    output logic                         done
);

    // Operand read side
    logic                         rd_en;
    ntt_defines_pkg::coeff_addr_t rd_addr;
    ntt_defines_pkg::coeff_t      a_data;
    ntt_defines_pkg::coeff_t      b_data;

    // Arithmetic stage
    logic                         issue_valid;
    ntt_defines_pkg::coeff_addr_t issue_addr;
    ntt_defines_pkg::mode_t       run_mode;
    ntt_defines_pkg::coeff_t      product;
    ntt_defines_pkg::coeff_t      sum;
    ntt_defines_pkg::coeff_t      diff;

    // Result write side
    logic                         c_wr_en;
    ntt_defines_pkg::coeff_addr_t c_wr_addr;
    ntt_defines_pkg::coeff_t      c_wr_data;

    // ============================================================
    // Coefficient memories
    // ============================================================

    ntt_coeff_ram ntt_mem_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .wr_en   (load_a_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (a_data)
    );

    ntt_coeff_ram ntt_mem_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .wr_en   (load_b_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (b_data)
    );

    ntt_coeff_ram ntt_mem_c (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .wr_en   (c_wr_en),
        .wr_addr (c_wr_addr),
        .wr_data (c_wr_data),
        .rd_en   (result_rd_en),
        .rd_addr (result_addr),
        .rd_data (result_data)
    );

    // ============================================================
    // Run datapath
    // ============================================================

    pwo_read_ctrl pwo_read_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pwo_enable  (pwo_enable),
        .mode        (mode),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .issue_valid (issue_valid),
        .issue_addr  (issue_addr),
        .run_mode    (run_mode),
        .busy        (busy)
    );

    pwo_mod_mul pwo_mod_mul_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .a       (a_data),
        .b       (b_data),
        .product (product)
    );

    pwo_mod_addsub pwo_mod_addsub_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a_data),
        .b     (b_data),
        .sum   (sum),
        .diff  (diff)
    );

    pwo_writeback pwo_writeback_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_addr  (issue_addr),
        .run_mode    (run_mode),
        .product     (product),
        .sum         (sum),
        .diff        (diff),
        .wr_en       (c_wr_en),
        .wr_addr     (c_wr_addr),
        .wr_data     (c_wr_data),
        .done        (done)
    );

endmodule

// File: tb/pwo_wrapper_asserts.sv
// Concurrent checks on the pointwise engine top level, attached to every pwo_wrapper through bind
`timescale 1ns/100ps

module pwo_wrapper_asserts (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         busy,
    input logic                         done,
    input logic                         rd_en,
    input ntt_defines_pkg::coeff_addr_t rd_addr,
    input logic                         c_wr_en,
    input ntt_defines_pkg::coeff_addr_t c_wr_addr,
    input ntt_defines_pkg::coeff_t      c_wr_data
);

    // Failure count, watched by the testbench
    int fail_count = 0;

    // ============================================================
    // Protocol and range checks
    // ============================================================

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // C is only written during a run
    write_while_busy: assert property (@(posedge clk) disable iff (!rst_n) c_wr_en |-> busy)
        else begin
            $error("write into C while busy is low");
            fail_count++;
        end

    // Every stored result is a reduced coefficient
    write_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> (c_wr_data < ntt_defines_pkg::MLDSA_Q))
        else begin
            $error("coefficient written into C is not below Q");
            fail_count++;
        end

    // Each write into C lands PWO_LATENCY cycles after the read of its address
    write_latency: assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> ($past(rd_en, ntt_defines_pkg::PWO_LATENCY) &&
                     (c_wr_addr == $past(rd_addr, ntt_defines_pkg::PWO_LATENCY))))
        else begin
            $error("write into C does not follow its read issue by the pipeline latency");
            fail_count++;
        end

endmodule

bind pwo_wrapper pwo_wrapper_asserts pwo_wrapper_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .done      (done),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .c_wr_en   (c_wr_en),
    .c_wr_addr (c_wr_addr),
    .c_wr_data (c_wr_data)
);

// File: tb/tb_pwo_wrapper.sv
// Directed testbench for the pointwise engine, used as the simulation top over the file list
`timescale 1ns/100ps

module tb_pwo_wrapper;

    logic                         clk;
    logic                         rst_n;
    logic                         zeroize;
    logic                         load_a_en;
    logic                         load_b_en;
    ntt_defines_pkg::coeff_addr_t load_addr;
    ntt_defines_pkg::coeff_t      load_data;
    logic                         pwo_enable;
    ntt_defines_pkg::mode_t       mode;
    logic                         result_rd_en;
    ntt_defines_pkg::coeff_addr_t result_addr;
    ntt_defines_pkg::coeff_t      result_data;
    logic                         busy;
    logic                         done;

    // Operand images for the reference model
    longint op_a [ntt_defines_pkg::MLDSA_N];
    longint op_b [ntt_defines_pkg::MLDSA_N];
    integer seed;

    pwo_wrapper UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .zeroize      (zeroize),
        .load_a_en    (load_a_en),
        .load_b_en    (load_b_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .pwo_enable   (pwo_enable),
        .mode         (mode),
        .result_rd_en (result_rd_en),
        .result_addr  (result_addr),
        .result_data  (result_data),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Bound checker watch
    always @(negedge clk) begin
        if (UUT.pwo_wrapper_asserts_inst.fail_count != 0) begin
            $display("A bound assertion failed before time %0t", $time);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input longint expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Reference model straight from the modular rules
    function automatic longint expected_coeff(input ntt_defines_pkg::mode_t m,
                                              input longint a, input longint b);
        longint q;
        q = ntt_defines_pkg::MLDSA_Q;
        case (m)
            ntt_defines_pkg::pwa: return (a + b) % q;
            ntt_defines_pkg::pws: return (a - b + q) % q;
            default:              return (a * b) % q;
        endcase
    endfunction

    // ============================================================
    // Bus tasks
    // ============================================================

    // Random operands with the edge pairs at the lowest addresses
    task automatic fill_operands();
        longint q;
        q = ntt_defines_pkg::MLDSA_Q;
        for (int i = 0; i < ntt_defines_pkg::MLDSA_N; i++) begin
            op_a[i] = {$random(seed)} % ntt_defines_pkg::MLDSA_Q;
            op_b[i] = {$random(seed)} % ntt_defines_pkg::MLDSA_Q;
        end
        op_a[0] = 0;
        op_b[0] = q - 1;
        op_a[1] = 1;
        op_b[1] = q - 1;
        op_a[2] = q - 1;
        op_b[2] = q - 1;
        op_a[3] = q - 1;
        op_b[3] = 1;
        op_a[4] = q - 1;
        op_b[4] = 0;
        op_a[5] = 5;
        op_b[5] = 100;
    endtask

    task automatic load_operands();
        for (int i = 0; i < ntt_defines_pkg::MLDSA_N; i++) begin
            @(posedge clk);
            load_a_en <= 1'b1;
            load_b_en <= 1'b0;
            load_addr <= ntt_defines_pkg::coeff_addr_t'(i);
            load_data <= ntt_defines_pkg::coeff_t'(op_a[i]);
            @(posedge clk);
            load_a_en <= 1'b0;
            load_b_en <= 1'b1;
            load_data <= ntt_defines_pkg::coeff_t'(op_b[i]);
        end
        @(posedge clk);
        load_b_en <= 1'b0;
    endtask

    task automatic start_run(input ntt_defines_pkg::mode_t m);
        @(posedge clk);
        pwo_enable <= 1'b1;
        mode       <= m;
        @(posedge clk);
        pwo_enable <= 1'b0;
    endtask

    // Counts cycles up to the done pulse, busy must stay high meanwhile
    task automatic wait_done(output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 1000) begin
                $display("Timeout: no done pulse within 1000 cycles of the start strobe");
                $display("Testbench failed");
                $fatal(1);
            end
            check_value("busy", 1, busy);
        end while (done !== 1'b1);
    endtask

    task automatic read_result(input int addr, output ntt_defines_pkg::coeff_t data);
        @(posedge clk);
        result_rd_en <= 1'b1;
        result_addr  <= ntt_defines_pkg::coeff_addr_t'(addr);
        @(posedge clk);
        result_rd_en <= 1'b0;
        @(negedge clk);
        data = result_data;
    endtask

    task automatic compare_results(input ntt_defines_pkg::mode_t m);
        ntt_defines_pkg::coeff_t data;
        for (int i = 0; i < ntt_defines_pkg::MLDSA_N; i++) begin
            read_result(i, data);
            check_value($sformatf("result_data[%0d]", i), expected_coeff(m, op_a[i], op_b[i]),
                        data);
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic run_and_check(input ntt_defines_pkg::mode_t m);
        int n;
        start_run(m);
        wait_done(n);
        check_value("done latency", ntt_defines_pkg::MLDSA_N + 4, n);
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        compare_results(m);
    endtask

    // Second strobe arrives mid-sweep with another mode
    task automatic second_strobe_ignored();
        int gap;
        int n;
        gap = 40;
        start_run(ntt_defines_pkg::pwm);
        repeat (gap) @(posedge clk);
        start_run(ntt_defines_pkg::pwa);
        wait_done(n);
        check_value("done latency", ntt_defines_pkg::MLDSA_N + 4, gap + 2 + n);
        for (int i = 0; i < 300; i++) begin
            @(negedge clk);
            check_value("done", 0, done);
        end
        compare_results(ntt_defines_pkg::pwm);
    endtask

    task automatic zeroize_clears_all();
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        for (int i = 0; i < ntt_defines_pkg::MLDSA_N; i++) begin
            op_a[i] = 0;
            op_b[i] = 0;
        end
        // C reads back as zero before the run rewrites it
        compare_results(ntt_defines_pkg::pwa);
        run_and_check(ntt_defines_pkg::pwa);
    endtask

    initial begin
        seed         = 171;
        rst_n        = 1'b0;
        zeroize      = 1'b0;
        load_a_en    = 1'b0;
        load_b_en    = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        pwo_enable   = 1'b0;
        mode         = ntt_defines_pkg::pwm;
        result_rd_en = 1'b0;
        result_addr  = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);

        fill_operands();
        load_operands();
        run_and_check(ntt_defines_pkg::pwm);
        run_and_check(ntt_defines_pkg::pwa);
        run_and_check(ntt_defines_pkg::pws);
        second_strobe_ignored();
        zeroize_clears_all();

        if (UUT.pwo_wrapper_asserts_inst.fail_count != 0) begin
            $display("Bound assertions reported %0d failures",
                     UUT.pwo_wrapper_asserts_inst.fail_count);
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
src/ntt_defines_pkg.sv
src/ntt_coeff_ram.sv
src/pwo_read_ctrl.sv
src/pwo_mod_mul.sv
src/pwo_mod_addsub.sv
src/pwo_writeback.sv
src/pwo_wrapper.sv
tb/pwo_wrapper_asserts.sv
tb/tb_pwo_wrapper.sv
